// File: source/core_types_pkg.sv
// Register file and translation table sizes, imported by every block on the core side
package core_types_pkg;

    // The core has one flat file of 64 registers
    localparam int reg_count = 64;
    localparam int reg_index_width = $clog2(reg_count);
    localparam int reg_data_width = 32;

    // A stored table entry holds a physical register index
    // Zero is reserved and marks a logical index as unmapped
    localparam int map_entry_width = 16;

endpackage

// File: source/endpoint_bus_pkg.sv
// Host bus widths and the control register layout, imported by the bus side of the endpoint
package endpoint_bus_pkg;

    localparam int bus_address_width = 8;
    localparam int bus_data_width = 32;

    // Word address of the control register
    localparam logic [bus_address_width-1:0] control_address = '0;

    // Each half of the control word is one field
    localparam int control_field_width = 16;

    // A bus word, taken either as plain data or as the control fields
    typedef union packed {
        logic [bus_data_width-1:0] raw;
        struct packed {
            logic [control_field_width-1:0] program_size;
            logic [control_field_width-1:0] n_channels;
        } fields;
    } control_word_u;

endpackage

// File: source/reg_stream_if.sv
// Valid/ready stream of register accesses, instantiated once per link between endpoint blocks
`timescale 1ns/1ps

interface reg_stream_if import core_types_pkg::*; ();

    // A transfer happens on an edge where valid and ready are both high
    logic valid;
    logic ready;
    logic [reg_index_width-1:0] dest;
    logic [reg_data_width-1:0] data;

    // The master holds valid, dest and data steady until the transfer
    modport master (
        output valid,
        output dest,
        output data,
        input ready
    );

    modport slave (
        input valid,
        input dest,
        input data,
        output ready
    );

endinterface

// File: source/bus_slave_port.sv
// Host bus front end of the DMA endpoint; turns bus strobes into register access streams
`timescale 1ns/1ps

module bus_slave_port import core_types_pkg::*, endpoint_bus_pkg::*; (
    input logic clock,
    input logic reset,
    input logic [bus_address_width-1:0] bus_address,
    input logic bus_write,
    input logic bus_read,
    input logic [bus_data_width-1:0] bus_write_data,
    output logic bus_ready,
    output logic [bus_data_width-1:0] bus_read_data,
    output logic bus_read_valid,
    reg_stream_if.master write_stream,
    reg_stream_if.master read_request,
    input logic [bus_data_width-1:0] read_data,
    input logic read_valid
);

    enum logic [1:0] {idle, write_pending, read_pending, read_wait} state;

    logic [reg_index_width-1:0] dest_q;
    logic [bus_data_width-1:0] data_q;

    // Only one access is in flight, so the bus stalls until it is done
    assign bus_ready = (state == idle);

    assign write_stream.valid = (state == write_pending);
    assign write_stream.dest = dest_q;
    assign write_stream.data = data_q;

    assign read_request.valid = (state == read_pending);
    assign read_request.dest = dest_q;
    assign read_request.data = '0;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            bus_read_valid <= 1'b0;
        end else begin
            bus_read_valid <= 1'b0;
            case (state)
                idle: begin
                    // A write strobe wins if both arrive together
                    if (bus_write) begin
                        state <= write_pending;
                    end else if (bus_read) begin
                        state <= read_pending;
                    end
                end
                write_pending: begin
                    if (write_stream.ready) begin
                        state <= idle;
                    end
                end
                read_pending: begin
                    if (read_request.ready) begin
                        state <= read_wait;
                    end
                end
                read_wait: begin
                    if (read_valid) begin
                        bus_read_valid <= 1'b1;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Address and data are captured while idle and then held for the stream
    always_ff @(posedge clock) begin
        if (state == idle) begin
            dest_q <= bus_address[reg_index_width-1:0];
            data_q <= bus_write_data;
        end
        if (state == read_wait && read_valid) begin
            bus_read_data <= read_data;
        end
    end

endmodule

// File: source/io_translation_table.sv
// Maps logical register indexes from the DMA side to physical registers of the core
`timescale 1ns/1ps

module io_translation_table import core_types_pkg::*; (
    input logic clock,
    input logic reset,
    input logic map_valid,
    input logic [2*map_entry_width-1:0] map_data,
    input logic [reg_index_width-1:0] write_lookup_index,
    input logic [reg_index_width-1:0] read_lookup_index,
    output logic [map_entry_width-1:0] write_lookup_entry,
    output logic [map_entry_width-1:0] read_lookup_entry
);

    logic [map_entry_width-1:0] map_table [reg_count];

    logic [reg_index_width-1:0] load_index;
    logic [map_entry_width-1:0] load_entry;

    // A map word carries the physical entry in its upper half
    // and the logical index in its lower half
    assign load_entry = map_data[2*map_entry_width-1:map_entry_width];
    assign load_index = map_data[reg_index_width-1:0];

    always_ff @(posedge clock) begin
        if (!reset) begin
            // Start out transparent, every index maps onto itself
            for (int i = 0; i < reg_count; i++) begin
                map_table[i] <= map_entry_width'(i);
            end
        end else if (map_valid) begin
            map_table[load_index] <= load_entry;
        end
    end

    // Write and read sides look up independently in the same cycle
    assign write_lookup_entry = map_table[write_lookup_index];
    assign read_lookup_entry = map_table[read_lookup_index];

endmodule

// File: source/dma_endpoint.sv
// Arbitrates host bus and DMA stream accesses to the core register file and holds the control word
`timescale 1ns/1ps

module dma_endpoint import core_types_pkg::*, endpoint_bus_pkg::*; (
    input logic clock,
    input logic reset,
    reg_stream_if.slave bus_write,
    reg_stream_if.slave bus_read_request,
    reg_stream_if.slave dma_write,
    reg_stream_if.slave dma_read_request,
    reg_stream_if.master dma_read_response,
    output logic [bus_data_width-1:0] read_data,
    output logic read_valid,
    output logic [reg_index_width-1:0] write_lookup_index,
    output logic [reg_index_width-1:0] read_lookup_index,
    input logic [map_entry_width-1:0] write_lookup_entry,
    input logic [map_entry_width-1:0] read_lookup_entry,
    output logic write_enable,
    output logic [reg_index_width-1:0] write_index,
    output logic [reg_data_width-1:0] write_data,
    output logic [reg_index_width-1:0] read_index,
    input logic [reg_data_width-1:0] read_word,
    output logic [control_field_width-1:0] n_channels,
    output logic [control_field_width-1:0] program_size
);

    enum logic [1:0] {idle, bus_read, stream_wait, stream_hold} read_state;

    control_word_u bus_word;
    control_word_u control_word_q;

    logic dma_first_q;
    logic dma_write_grant;
    logic bus_write_grant;
    logic bus_write_control;

    logic read_unmapped_q;
    logic read_control_q;
    logic read_valid_q;
    logic [bus_data_width-1:0] read_data_q;
    logic [reg_data_width-1:0] response_data_q;
    logic [reg_index_width-1:0] response_dest_q;

    // The DMA side always goes through the table
    assign write_lookup_index = dma_write.dest;
    assign read_lookup_index = dma_read_request.dest;

    // On contention only the stream that has priority sees ready
    assign dma_write.ready = !bus_write.valid || dma_first_q;
    assign bus_write.ready = !dma_write.valid || !dma_first_q;
    assign dma_write_grant = dma_write.valid && dma_write.ready;
    assign bus_write_grant = bus_write.valid && bus_write.ready;

    assign bus_word = bus_write.data;
    assign bus_write_control = (bus_write.dest == reg_index_width'(control_address));

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_enable <= 1'b0;
            dma_first_q <= 1'b0;
            control_word_q <= '0;
        end else begin
            write_enable <= 1'b0;
            if (dma_write_grant) begin
                // Unmapped DMA writes are accepted and then dropped
                write_enable <= (write_lookup_entry != '0);
            end else if (bus_write_grant && !bus_write_control) begin
                write_enable <= 1'b1;
            end
            if (bus_write_grant && bus_write_control) begin
                control_word_q.fields <= bus_word.fields;
            end
            if (bus_write.valid && dma_write.valid) begin
                dma_first_q <= !dma_first_q;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dma_write_grant) begin
            write_index <= write_lookup_entry[reg_index_width-1:0];
            write_data <= dma_write.data;
        end else begin
            write_index <= bus_write.dest;
            write_data <= bus_word.raw;
        end
    end

    assign n_channels = control_word_q.fields.n_channels;
    assign program_size = control_word_q.fields.program_size;

    // Register file is addressed straight from the request that wins in idle,
    // so read_word is ready one edge after acceptance
    assign read_index = dma_read_request.valid ? read_lookup_entry[reg_index_width-1:0]
                                               : bus_read_request.dest;

    assign dma_read_request.ready = (read_state == idle);
    assign bus_read_request.ready = (read_state == idle) && !dma_read_request.valid;

    assign dma_read_response.valid = (read_state == stream_hold);
    assign dma_read_response.data = response_data_q;
    assign dma_read_response.dest = response_dest_q;

    assign read_data = read_data_q;
    assign read_valid = read_valid_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            read_state <= idle;
            read_valid_q <= 1'b0;
        end else begin
            read_valid_q <= 1'b0;
            case (read_state)
                idle: begin
                    if (dma_read_request.valid) begin
                        read_state <= stream_wait;
                    end else if (bus_read_request.valid) begin
                        read_state <= bus_read;
                    end
                end
                stream_wait: read_state <= stream_hold;
                stream_hold: begin
                    if (dma_read_response.ready) begin
                        read_state <= idle;
                    end
                end
                bus_read: begin
                    read_valid_q <= 1'b1;
                    read_state <= idle;
                end
                default: read_state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (read_state == idle) begin
            read_unmapped_q <= (read_lookup_entry == '0);
            read_control_q <= (bus_read_request.dest == reg_index_width'(control_address));
            response_dest_q <= dma_read_request.dest;
        end
        // Response data is captured once and held until it is taken
        if (read_state == stream_wait) begin
            response_data_q <= read_unmapped_q ? '0 : read_word;
        end
        if (read_state == bus_read) begin
            read_data_q <= read_control_q ? control_word_q.raw : read_word;
        end
    end

endmodule

// File: source/core_register_file.sv
// Register file of the soft core, written and read by the DMA endpoint
`timescale 1ns/1ps

module core_register_file import core_types_pkg::*; (
    input logic clock,
    input logic reset,
    input logic write_enable,
    input logic [reg_index_width-1:0] write_index,
    input logic [reg_data_width-1:0] write_data,
    input logic [reg_index_width-1:0] read_index,
    output logic [reg_data_width-1:0] read_word
);

    logic [reg_data_width-1:0] registers [reg_count];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < reg_count; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable) begin
            registers[write_index] <= write_data;
        end
    end

    // A read of the register being written returns the new word
    always_ff @(posedge clock) begin
        if (write_enable && write_index == read_index) begin
            read_word <= write_data;
        end else begin
            read_word <= registers[read_index];
        end
    end

endmodule

// File: source/dma_subsystem.sv
// Top level of the register file DMA endpoint; exposes the host bus, map load and DMA streams
`timescale 1ns/1ps

module dma_subsystem import core_types_pkg::*, endpoint_bus_pkg::*; (
    input logic clock,
    input logic reset,
    input logic [bus_address_width-1:0] bus_address,
    input logic bus_write,
    input logic bus_read,
    input logic [bus_data_width-1:0] bus_write_data,
    output logic bus_ready,
    output logic [bus_data_width-1:0] bus_read_data,
    output logic bus_read_valid,
    input logic map_valid,
    input logic [2*map_entry_width-1:0] map_data,
    input logic dma_write_valid,
    output logic dma_write_ready,
    input logic [reg_index_width-1:0] dma_write_index,
    input logic [reg_data_width-1:0] dma_write_data,
    input logic dma_read_request_valid,
    output logic dma_read_request_ready,
    input logic [reg_index_width-1:0] dma_read_request_index,
    output logic dma_read_response_valid,
    input logic response_ready,
    output logic [reg_data_width-1:0] dma_read_response_data,
    output logic [control_field_width-1:0] n_channels,
    output logic [control_field_width-1:0] program_size
);

    reg_stream_if bus_write_stream ();
    reg_stream_if bus_read_request ();
    reg_stream_if dma_write ();
    reg_stream_if dma_read_request ();
    reg_stream_if dma_read_response ();

    logic [bus_data_width-1:0] endpoint_read_data;
    logic endpoint_read_valid;
    logic [reg_index_width-1:0] write_lookup_index;
    logic [reg_index_width-1:0] read_lookup_index;
    logic [map_entry_width-1:0] write_lookup_entry;
    logic [map_entry_width-1:0] read_lookup_entry;
    logic write_enable;
    logic [reg_index_width-1:0] write_index;
    logic [reg_data_width-1:0] write_data;
    logic [reg_index_width-1:0] read_index;
    logic [reg_data_width-1:0] read_word;

    // DMA streams arrive and leave as plain ports
    assign dma_write.valid = dma_write_valid;
    assign dma_write.dest = dma_write_index;
    assign dma_write.data = dma_write_data;
    assign dma_write_ready = dma_write.ready;

    assign dma_read_request.valid = dma_read_request_valid;
    assign dma_read_request.dest = dma_read_request_index;
    assign dma_read_request.data = '0;
    assign dma_read_request_ready = dma_read_request.ready;

    assign dma_read_response_valid = dma_read_response.valid;
    assign dma_read_response_data = dma_read_response.data;
    assign dma_read_response.ready = response_ready;

    bus_slave_port bus_slave_port_i (
        .clock(clock),
        .reset(reset),
        .bus_address(bus_address),
        .bus_write(bus_write),
        .bus_read(bus_read),
        .bus_write_data(bus_write_data),
        .bus_ready(bus_ready),
        .bus_read_data(bus_read_data),
        .bus_read_valid(bus_read_valid),
        .write_stream(bus_write_stream.master),
        .read_request(bus_read_request.master),
        .read_data(endpoint_read_data),
        .read_valid(endpoint_read_valid)
    );

    io_translation_table io_translation_table_i (
        .clock(clock),
        .reset(reset),
        .map_valid(map_valid),
        .map_data(map_data),
        .write_lookup_index(write_lookup_index),
        .read_lookup_index(read_lookup_index),
        .write_lookup_entry(write_lookup_entry),
        .read_lookup_entry(read_lookup_entry)
    );

    dma_endpoint dma_endpoint_i (
        .clock(clock),
        .reset(reset),
        .bus_write(bus_write_stream.slave),
        .bus_read_request(bus_read_request.slave),
        .dma_write(dma_write.slave),
        .dma_read_request(dma_read_request.slave),
        .dma_read_response(dma_read_response.master),
        .read_data(endpoint_read_data),
        .read_valid(endpoint_read_valid),
        .write_lookup_index(write_lookup_index),
        .read_lookup_index(read_lookup_index),
        .write_lookup_entry(write_lookup_entry),
        .read_lookup_entry(read_lookup_entry),
        .write_enable(write_enable),
        .write_index(write_index),
        .write_data(write_data),
        .read_index(read_index),
        .read_word(read_word),
        .n_channels(n_channels),
        .program_size(program_size)
    );

    core_register_file core_register_file_i (
        .clock(clock),
        .reset(reset),
        .write_enable(write_enable),
        .write_index(write_index),
        .write_data(write_data),
        .read_index(read_index),
        .read_word(read_word)
    );

endmodule

// File: sim/clock_gen.sv
// Free-running clock for the testbench, instantiated once by the testbench top
`timescale 1ns/1ps

module clock_gen (
    output logic clock
);

    // Half of the 8 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

endmodule

// File: sim/dma_subsystem_tb.sv
// Table-driven testbench for the DMA subsystem that runs as the simulation top from the file list
`timescale 1ns/1ps

module dma_subsystem_tb import core_types_pkg::*, endpoint_bus_pkg::*;;

    localparam int op_bus_write = 0;
    localparam int op_bus_read = 1;
    localparam int op_map_load = 2;
    localparam int op_dma_write = 3;
    localparam int op_dma_read = 4;
    localparam int op_dual_write = 5;

    localparam int sig_bus_ready = 0;
    localparam int sig_bus_read_valid = 1;
    localparam int sig_write_ready = 2;
    localparam int sig_request_ready = 3;
    localparam int sig_response_valid = 4;
    localparam int sig_response_taken = 5;
    localparam int wait_limit = 200;

    typedef struct {
        int op;
        logic [reg_index_width-1:0] addr;
        logic [31:0] data;
        logic [reg_index_width-1:0] addr2;
        logic [31:0] data2;
        logic [31:0] expected;
        logic [31:0] control;
    } step_t;

    logic clock;
    logic reset;
    logic [bus_address_width-1:0] bus_address;
    logic bus_write;
    logic bus_read;
    logic [bus_data_width-1:0] bus_write_data;
    logic bus_ready;
    logic [bus_data_width-1:0] bus_read_data;
    logic bus_read_valid;
    logic map_valid;
    logic [2*map_entry_width-1:0] map_data;
    logic dma_write_valid;
    logic dma_write_ready;
    logic [reg_index_width-1:0] dma_write_index;
    logic [reg_data_width-1:0] dma_write_data;
    logic dma_read_request_valid;
    logic dma_read_request_ready;
    logic [reg_index_width-1:0] dma_read_request_index;
    logic dma_read_response_valid;
    logic response_ready = 1'b0;
    logic [reg_data_width-1:0] dma_read_response_data;
    logic [control_field_width-1:0] n_channels;
    logic [control_field_width-1:0] program_size;

    // Reference model of the registers, the map and the control word
    logic [31:0] model_regs [reg_count];
    logic [map_entry_width-1:0] model_map [reg_count];
    logic [31:0] model_control;
    step_t steps [$];

    integer seed = 32'h2bf4;
    logic [31:0] ready_draw;
    int error_count = 0;
    int timeout_count = 0;
    int check_count = 0;
    logic response_pending = 1'b0;
    logic request_open = 1'b0;
    logic [31:0] held_data;

    clock_gen clock_gen_i (.clock(clock));

    dma_subsystem dma_subsystem_i (.*);

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic logic signal_level(input int which);
        case (which)
            sig_bus_ready: return bus_ready;
            sig_bus_read_valid: return bus_read_valid;
            sig_write_ready: return dma_write_ready;
            sig_request_ready: return dma_read_request_ready;
            sig_response_valid: return dma_read_response_valid;
            default: return dma_read_response_valid && response_ready;
        endcase
    endfunction

    // Samples on falling edges, where every DUT output has settled
    task automatic wait_until_high(input int which, input string what, output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!signal_level(which) && cycles < wait_limit);
        if (!signal_level(which)) begin
            timeout_count++;
            $display("Timeout at %0t ns: %s did not go high within %0d cycles",
                     $time, what, wait_limit);
        end
    endtask

    task automatic add_step(input int op, input logic [reg_index_width-1:0] addr,
                            input logic [31:0] data = '0,
                            input logic [reg_index_width-1:0] addr2 = '0,
                            input logic [31:0] data2 = '0);
        step_t step;
        logic [map_entry_width-1:0] entry;
        step.op = op;
        step.addr = addr;
        step.data = data;
        step.addr2 = addr2;
        step.data2 = data2;
        step.expected = '0;
        entry = model_map[(op == op_dual_write) ? addr2 : addr];
        case (op)
            op_bus_write, op_dual_write: begin
                if (addr == '0) begin
                    model_control = data;
                end else begin
                    model_regs[addr] = data;
                end
            end
            op_map_load: model_map[addr] = data[map_entry_width-1:0];
            op_bus_read: step.expected = (addr == '0) ? model_control : model_regs[addr];
            op_dma_read: begin
                step.expected = (entry == '0) ? '0 : model_regs[entry[reg_index_width-1:0]];
            end
            default: ;
        endcase
        // An entry of zero is unmapped and swallows the DMA write
        if ((op == op_dma_write || op == op_dual_write) && entry != '0) begin
            model_regs[entry[reg_index_width-1:0]] = (op == op_dual_write) ? data2 : data;
        end
        step.control = model_control;
        steps.push_back(step);
    endtask

    task automatic bus_write_word(input logic [reg_index_width-1:0] addr, input logic [31:0] value);
        int cycles;
        wait_until_high(sig_bus_ready, "bus_ready", cycles);
        @(posedge clock);
        bus_write <= 1'b1;
        bus_address <= bus_address_width'(addr);
        bus_write_data <= value;
        @(posedge clock);
        bus_write <= 1'b0;
        wait_until_high(sig_bus_ready, "bus_ready after a write", cycles);
    endtask

    task automatic bus_read_word(input logic [reg_index_width-1:0] addr, input logic [31:0] expected);
        int cycles;
        wait_until_high(sig_bus_ready, "bus_ready", cycles);
        @(posedge clock);
        bus_read <= 1'b1;
        bus_address <= bus_address_width'(addr);
        @(posedge clock);
        bus_read <= 1'b0;
        wait_until_high(sig_bus_read_valid, "bus_read_valid", cycles);
        check_value("bus_read_data", bus_read_data, expected);
    endtask

    task automatic load_map_entry(input logic [reg_index_width-1:0] index,
                                  input logic [map_entry_width-1:0] entry);
        @(posedge clock);
        map_valid <= 1'b1;
        map_data <= {entry, map_entry_width'(index)};
        @(posedge clock);
        map_valid <= 1'b0;
    endtask

    task automatic dma_write_word(input logic [reg_index_width-1:0] index, input logic [31:0] value);
        int cycles;
        @(posedge clock);
        dma_write_valid <= 1'b1;
        dma_write_index <= index;
        dma_write_data <= value;
        wait_until_high(sig_write_ready, "dma_write_ready", cycles);
        @(posedge clock);
        dma_write_valid <= 1'b0;
    endtask

    task automatic dma_read_word(input logic [reg_index_width-1:0] index, input logic [31:0] expected);
        int cycles;
        @(posedge clock);
        dma_read_request_valid <= 1'b1;
        dma_read_request_index <= index;
        wait_until_high(sig_request_ready, "dma_read_request_ready", cycles);
        @(posedge clock);
        dma_read_request_valid <= 1'b0;
        // The response is due two edges after the request is accepted
        wait_until_high(sig_response_valid, "dma_read_response_valid", cycles);
        check_value("response latency", 32'(cycles), 32'd2);
        check_value("dma_read_response_data", dma_read_response_data, expected);
        // A response that is ready right away is taken on the next edge
        if (!response_ready) begin
            wait_until_high(sig_response_taken, "the response handshake", cycles);
        end
        @(posedge clock);
    endtask

    // Random back-pressure makes the response ready on about three edges in four
    always @(posedge clock) begin
        ready_draw = $random(seed);
        response_ready <= (ready_draw[1:0] != 2'b00);
    end

    // A response that is not taken must stay valid with the same data
    always @(negedge clock) begin
        if (reset) begin
            if (response_pending && !dma_read_response_valid) begin
                error_count++;
                $display("Failure at %0t ns: read response dropped before it was taken", $time);
            end
            if (dma_read_response_valid && response_pending) begin
                check_value("dma_read_response_data (held)", dma_read_response_data, held_data);
            end
            if (dma_read_response_valid && dma_read_request_ready) begin
                error_count++;
                $display("Failure at %0t ns: read request ready while a response waits", $time);
            end
            // Each accepted request is answered by exactly one response
            if (dma_read_response_valid && !request_open) begin
                error_count++;
                $display("Failure at %0t ns: read response without an outstanding request",
                         $time);
            end
            response_pending = dma_read_response_valid && !response_ready;
            held_data = dma_read_response_data;
            if (dma_read_response_valid && response_ready) begin
                request_open = 1'b0;
            end else if (dma_read_request_valid && dma_read_request_ready) begin
                request_open = 1'b1;
            end
        end
    end

    initial begin
        logic [31:0] pick;
        reset <= 1'b0;
        bus_address <= '0;
        bus_write <= 1'b0;
        bus_read <= 1'b0;
        bus_write_data <= '0;
        map_valid <= 1'b0;
        map_data <= '0;
        dma_write_valid <= 1'b0;
        dma_write_index <= '0;
        dma_write_data <= '0;
        dma_read_request_valid <= 1'b0;
        dma_read_request_index <= '0;
        model_control = '0;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
            model_map[i] = map_entry_width'(i);
        end

        // Everything reads as zero straight out of reset
        add_step(op_bus_read, 6'd0);
        add_step(op_bus_read, 6'd5);
        add_step(op_bus_read, 6'd63);
        add_step(op_dma_read, 6'd17);
        // Raw sweep over every register and then the control word
        for (int i = 1; i < reg_count; i++) begin
            add_step(op_bus_write, 6'(i), 32'h5a00_0000 ^ (32'(i) * 32'h0001_0203));
        end
        for (int i = 1; i < reg_count; i++) begin
            add_step(op_bus_read, 6'(i));
        end
        add_step(op_bus_write, 6'd0, 32'h0010_0004);
        add_step(op_bus_read, 6'd0);
        // Transparent and remapped DMA accesses
        add_step(op_dma_write, 6'd7, 32'hcafe_0007);
        add_step(op_dma_read, 6'd7);
        add_step(op_map_load, 6'd9, 32'd20);
        add_step(op_dma_write, 6'd9, 32'h1234_0009);
        add_step(op_bus_read, 6'd20);
        add_step(op_dma_read, 6'd9);
        // Unmapped entries
        add_step(op_dma_write, 6'd0, 32'hdead_0000);
        add_step(op_map_load, 6'd12, 32'd0);
        add_step(op_dma_write, 6'd12, 32'hdead_000c);
        add_step(op_bus_read, 6'd12);
        add_step(op_dma_read, 6'd12);
        add_step(op_dma_read, 6'd0);
        repeat (40) begin
            pick = $random(seed);
            add_step(op_dma_read, pick[reg_index_width-1:0]);
        end
        // Bus and DMA writes competing for the register file
        add_step(op_dual_write, 6'd30, 32'h0bad_001e, 6'd31, 32'h600d_001f);
        add_step(op_dual_write, 6'd40, 32'h0bad_0028, 6'd41, 32'h600d_0029);
        add_step(op_bus_read, 6'd30);
        add_step(op_bus_read, 6'd31);
        add_step(op_bus_read, 6'd40);
        add_step(op_bus_read, 6'd41);

        repeat (4) @(posedge clock);
        reset <= 1'b1;

        foreach (steps[i]) begin
            case (steps[i].op)
                op_bus_write: bus_write_word(steps[i].addr, steps[i].data);
                op_bus_read: bus_read_word(steps[i].addr, steps[i].expected);
                op_map_load: load_map_entry(steps[i].addr, steps[i].data[map_entry_width-1:0]);
                op_dma_write: dma_write_word(steps[i].addr, steps[i].data);
                op_dma_read: dma_read_word(steps[i].addr, steps[i].expected);
                default: begin
                    // The DMA valid rises while the bus write is still pending
                    fork
                        bus_write_word(steps[i].addr, steps[i].data);
                        begin
                            repeat (2) @(posedge clock);
                            dma_write_word(steps[i].addr2, steps[i].data2);
                        end
                    join
                end
            endcase
            @(negedge clock);
            check_value("n_channels", 32'(n_channels), 32'(steps[i].control[15:0]));
            check_value("program_size", 32'(program_size), 32'(steps[i].control[31:16]));
        end

        $display("Summary: %0d checks, %0d errors, %0d timeouts",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: dma_subsystem.f
source/core_types_pkg.sv
source/endpoint_bus_pkg.sv
source/reg_stream_if.sv
source/bus_slave_port.sv
source/io_translation_table.sv
source/dma_endpoint.sv
source/core_register_file.sv
source/dma_subsystem.sv
sim/clock_gen.sv
sim/dma_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
verilator --binary --timing --top-module dma_subsystem_tb -f dma_subsystem.f \
    -o dma_subsystem_sim \
    && ./obj_dir/dma_subsystem_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "Simulation reported failures"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "No result found in the log"; exit 1; }
exit 0
